// ==== include/psram_ctrl_macros.svh ====
`ifndef PSRAM_CTRL_MACROS_SVH
`define PSRAM_CTRL_MACROS_SVH

// Host side widths
`define PSRAM_DATA_W      32
`define PSRAM_ADDR_W      32

// OPI bus width
`define PSRAM_BYTE_W      8

// Device geometry
`define PSRAM_MEM_WORDS   1024
`define PSRAM_REG_COUNT   4

// Bus timing in clk cycles
`define PSRAM_LATENCY     5   // Read dummy cycles
`define PSRAM_CSHI        3   // Minimum CS high between transactions

`define PSRAM_CMD_MEM_RD  8'h20
`define PSRAM_CMD_MEM_WR  8'hA0
`define PSRAM_CMD_REG_RD  8'h40
`define PSRAM_CMD_REG_WR  8'hC0

`endif

// ==== rtl/axil_pkg.sv ====
`default_nettype none

`include "psram_ctrl_macros.svh"

package axil_pkg;

   typedef enum logic [1:0] {
      AXIL_OKAY   = 2'd0,
      AXIL_SLVERR = 2'd2,
      AXIL_DECERR = 2'd3
   } axil_resp_e;

   // Host driven side
   typedef struct packed {
      logic                        awvalid;
      logic [`PSRAM_ADDR_W-1:0]    awaddr;
      logic                        wvalid;
      logic [`PSRAM_DATA_W-1:0]    wdata;
      logic [`PSRAM_DATA_W/8-1:0]  wstrb;
      logic                        bready;
      logic                        arvalid;
      logic [`PSRAM_ADDR_W-1:0]    araddr;
      logic                        rready;
   } axil_req_t;

   typedef struct packed {
      logic                        awready;
      logic                        wready;
      logic                        bvalid;
      axil_resp_e                  bresp;
      logic                        arready;
      logic                        rvalid;
      logic [`PSRAM_DATA_W-1:0]    rdata;
      axil_resp_e                  rresp;
   } axil_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/opi_pkg.sv ====
`default_nettype none

`include "psram_ctrl_macros.svh"

package opi_pkg;

   localparam int OFF_W      = $clog2(`PSRAM_DATA_W / 8);
   localparam int WIDX_W     = $clog2(`PSRAM_MEM_WORDS);
   localparam int RIDX_W     = $clog2(`PSRAM_REG_COUNT);
   localparam int MEM_RSVD_W = `PSRAM_ADDR_W - 1 - WIDX_W - OFF_W;
   localparam int CFG_RSVD_W = `PSRAM_ADDR_W - 1 - RIDX_W;

   // Memory array view of a host address
   typedef struct packed {
      logic                    target;   // 0 here
      logic [MEM_RSVD_W-1:0]   rsvd;
      logic [WIDX_W-1:0]       word_idx;
      logic [OFF_W-1:0]        byte_off;
   } opi_mem_addr_t;

   // Config register view, no byte lane
   typedef struct packed {
      logic                    target;   // 1 here
      logic [CFG_RSVD_W-1:0]   rsvd;
      logic [RIDX_W-1:0]       reg_idx;
   } opi_cfg_addr_t;

   typedef union packed {
      opi_mem_addr_t mem;
      opi_cfg_addr_t cfg;
   } opi_addr_u;

   typedef struct packed {
      logic                        wr;
      logic [`PSRAM_BYTE_W-1:0]    cmd_byte;
      logic [`PSRAM_ADDR_W-1:0]    addr;
      logic [`PSRAM_DATA_W-1:0]    wdata;
   } opi_cmd_t;

   typedef struct packed {
      logic                        ce_n;
      logic                        ck_en;
      logic [`PSRAM_BYTE_W-1:0]    dq_out;
      logic                        dq_oe;
      logic                        sample;   // Input byte of this cycle is read data
   } opi_slot_t;

   typedef struct packed {
      logic                        ce_n;
      logic                        ck_en;
      logic [`PSRAM_BYTE_W-1:0]    dq_out;
      logic                        dq_oe;
   } opi_pins_t;

endpackage

`default_nettype wire

// ==== rtl/axil_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psram_ctrl_macros.svh"

module axil_port (
   input  logic                      clk,
   input  logic                      rst,
   input  axil_pkg::axil_req_t       axil_req,
   output axil_pkg::axil_rsp_t       axil_rsp,
   output opi_pkg::opi_cmd_t         cmd,
   output logic                      cmd_valid,
   input  logic                      cmd_ready,
   input  logic                      wr_done,
   input  logic [`PSRAM_DATA_W-1:0]  rd_word,
   input  logic                      rd_valid
);
   import axil_pkg::*;
   import opi_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_RESP} state_e;

   state_e                    state;
   logic                      wr_q;      // Current transaction is a write
   logic                      aw_go;
   logic                      ar_go;
   opi_addr_u                 addr_u;
   logic                      tgt_cfg;
   logic                      slv_err;
   logic                      dec_err;
   axil_resp_e                err_resp;
   logic [`PSRAM_BYTE_W-1:0]  cmd_byte;
   logic [`PSRAM_ADDR_W-1:0]  dev_addr;
   logic                      bvalid_q;
   axil_resp_e                bresp_q;
   logic                      rvalid_q;
   logic [`PSRAM_DATA_W-1:0]  rdata_q;
   axil_resp_e                rresp_q;

   // AW and W taken together, write before read
   assign aw_go = (state == S_IDLE) && axil_req.awvalid && axil_req.wvalid;
   assign ar_go = (state == S_IDLE) && axil_req.arvalid &&
                  !(axil_req.awvalid && axil_req.wvalid);

   always_comb begin
      addr_u  = aw_go ? axil_req.awaddr : axil_req.araddr;
      tgt_cfg = addr_u.mem.target;
      // Alignment only matters for the memory array
      slv_err = (!tgt_cfg && addr_u.mem.byte_off != '0) ||
                (aw_go && axil_req.wstrb != '1);
      if (tgt_cfg) begin
         dec_err  = {addr_u.cfg.rsvd, addr_u.cfg.reg_idx} >= `PSRAM_REG_COUNT;
         dev_addr = `PSRAM_ADDR_W'(addr_u.cfg.reg_idx);
         cmd_byte = aw_go ? `PSRAM_CMD_REG_WR : `PSRAM_CMD_REG_RD;
      end else begin
         dec_err  = {addr_u.mem.rsvd, addr_u.mem.word_idx} >= `PSRAM_MEM_WORDS;
         dev_addr = `PSRAM_ADDR_W'(addr_u.mem.word_idx);
         cmd_byte = aw_go ? `PSRAM_CMD_MEM_WR : `PSRAM_CMD_MEM_RD;
      end
      if (slv_err)
         err_resp = AXIL_SLVERR;
      else if (dec_err)
         err_resp = AXIL_DECERR;
      else
         err_resp = AXIL_OKAY;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= S_IDLE;
         wr_q      <= 1'b0;
         cmd_valid <= 1'b0;
         bvalid_q  <= 1'b0;
         rvalid_q  <= 1'b0;
      end else begin
         case (state)
            S_IDLE: if (aw_go || ar_go) begin
               wr_q <= aw_go;
               if (slv_err || dec_err) begin   // Answered without bus traffic
                  bvalid_q <= aw_go;
                  rvalid_q <= ar_go;
                  state    <= S_RESP;
               end else begin
                  cmd_valid <= 1'b1;
                  state     <= S_ISSUE;
               end
            end
            S_ISSUE: if (cmd_ready) begin
               cmd_valid <= 1'b0;
               state     <= S_WAIT;
            end
            S_WAIT: begin
               if (wr_q && wr_done) begin
                  bvalid_q <= 1'b1;
                  state    <= S_RESP;
               end else if (!wr_q && rd_valid) begin
                  rvalid_q <= 1'b1;
                  state    <= S_RESP;
               end
            end
            default: if ((bvalid_q && axil_req.bready) || (rvalid_q && axil_req.rready)) begin
               bvalid_q <= 1'b0;
               rvalid_q <= 1'b0;
               state    <= S_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (aw_go || ar_go) begin
         cmd <= '{wr: aw_go, cmd_byte: cmd_byte, addr: dev_addr, wdata: axil_req.wdata};
         if (aw_go) begin
            bresp_q <= err_resp;
         end else begin
            rresp_q <= err_resp;
            rdata_q <= '0;
         end
      end else if (state == S_WAIT && !wr_q && rd_valid) begin
         rdata_q <= rd_word;
      end
   end

   assign axil_rsp = '{awready: aw_go, wready: aw_go, bvalid: bvalid_q, bresp: bresp_q,
                       arready: ar_go, rvalid: rvalid_q, rdata: rdata_q, rresp: rresp_q};

   // Responses held steady under back-pressure
   a_b_hold: assert property (@(posedge clk) disable iff (rst)
      bvalid_q && !axil_req.bready |=> bvalid_q && $stable(bresp_q));
   a_r_hold: assert property (@(posedge clk) disable iff (rst)
      rvalid_q && !axil_req.rready |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q));

endmodule

`default_nettype wire

// ==== rtl/opi_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psram_ctrl_macros.svh"

module opi_sequencer (
   input  logic               clk,
   input  logic               rst,
   input  opi_pkg::opi_cmd_t  cmd,
   input  logic               cmd_valid,
   output logic               cmd_ready,
   output opi_pkg::opi_slot_t slot,
   output logic               wr_done
);
   import opi_pkg::*;

   localparam int SH_W       = `PSRAM_BYTE_W + `PSRAM_ADDR_W + `PSRAM_DATA_W;
   localparam int ADDR_BYTES = `PSRAM_ADDR_W / `PSRAM_BYTE_W;
   localparam int DATA_BYTES = `PSRAM_DATA_W / `PSRAM_BYTE_W;
   localparam int CNT_W      = $clog2(`PSRAM_LATENCY + `PSRAM_CSHI + DATA_BYTES);
   localparam opi_slot_t SLOT_IDLE = '{ce_n: 1'b1, ck_en: 1'b0, dq_out: '0,
                                       dq_oe: 1'b0, sample: 1'b0};

   typedef enum logic [2:0] {S_IDLE, S_CMD, S_ADDR, S_LAT, S_DATA, S_GAP} state_e;

   state_e            state;
   logic [CNT_W-1:0]  cnt;        // Cycle within current phase
   logic [CNT_W-1:0]  cnt_lim;
   logic              cnt_last;
   logic              wr_q;
   logic [SH_W-1:0]   sh;         // Command, address and write data, MSB out first

   always_comb begin
      case (state)
         S_ADDR:  cnt_lim = CNT_W'(ADDR_BYTES - 1);
         S_LAT:   cnt_lim = CNT_W'(`PSRAM_LATENCY - 1);
         S_DATA:  cnt_lim = CNT_W'(DATA_BYTES - 1);
         S_GAP:   cnt_lim = CNT_W'(`PSRAM_CSHI - 1);
         default: cnt_lim = '0;
      endcase
   end

   assign cnt_last  = (cnt == cnt_lim);
   assign cmd_ready = (state == S_IDLE);
   assign wr_done   = (state == S_DATA) && wr_q && cnt_last;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
         cnt   <= '0;
         wr_q  <= 1'b0;
      end else if (state == S_IDLE) begin
         if (cmd_valid) begin
            wr_q  <= cmd.wr;
            state <= S_CMD;
         end
      end else if (!cnt_last) begin
         cnt <= cnt + 1'b1;
      end else begin
         cnt <= '0;
         case (state)
            S_CMD:   state <= S_ADDR;
            S_ADDR:  state <= wr_q ? S_DATA : S_LAT;   // Writes have no latency
            S_LAT:   state <= S_DATA;
            S_DATA:  state <= S_GAP;
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_IDLE && cmd_valid)
         sh <= {cmd.cmd_byte, cmd.addr, cmd.wdata};
      else if (state == S_CMD || state == S_ADDR || state == S_DATA)
         sh <= {sh[SH_W-`PSRAM_BYTE_W-1:0], {`PSRAM_BYTE_W{1'b0}}};
   end

   always_comb begin
      slot = SLOT_IDLE;
      case (state)
         S_CMD, S_ADDR: begin
            slot.ce_n   = 1'b0;
            slot.ck_en  = 1'b1;
            slot.dq_out = sh[SH_W-1 -: `PSRAM_BYTE_W];
            slot.dq_oe  = 1'b1;
         end
         S_LAT: begin   // Dummy cycles, bus released
            slot.ce_n  = 1'b0;
            slot.ck_en = 1'b1;
         end
         S_DATA: begin
            slot.ce_n  = 1'b0;
            slot.ck_en = 1'b1;
            if (wr_q) begin
               slot.dq_out = sh[SH_W-1 -: `PSRAM_BYTE_W];
               slot.dq_oe  = 1'b1;
            end else begin
               slot.sample = 1'b1;
            end
         end
         default: ;
      endcase
   end

   // No drive in a sample slot or in the slot after it, when the device replies
   a_no_contention: assert property (@(posedge clk) disable iff (rst)
      slot.dq_oe |-> !slot.sample && !$past(slot.sample));

endmodule

`default_nettype wire

// ==== rtl/opi_io.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psram_ctrl_macros.svh"

module opi_io (
   input  logic                      clk,
   input  logic                      rst,
   input  opi_pkg::opi_slot_t        slot,
   output opi_pkg::opi_pins_t        pins,
   input  logic [`PSRAM_BYTE_W-1:0]  dq_in,
   output logic [`PSRAM_DATA_W-1:0]  rd_word,
   output logic                      rd_valid
);
   import opi_pkg::*;

   localparam int HOLD_W  = `PSRAM_DATA_W - `PSRAM_BYTE_W;
   localparam int NBYTES  = `PSRAM_DATA_W / `PSRAM_BYTE_W;
   localparam int BCNT_W  = $clog2(NBYTES);
   localparam opi_pins_t PINS_IDLE = '{ce_n: 1'b1, ck_en: 1'b0, dq_out: '0, dq_oe: 1'b0};

   logic               sample_q;   // Aligned with pins
   logic               sample_d;   // Aligned with device data
   logic [BCNT_W-1:0]  byte_cnt;
   logic [HOLD_W-1:0]  rd_hold;    // Earlier bytes of the word

   always_ff @(posedge clk) begin
      if (rst) begin
         pins     <= PINS_IDLE;
         sample_q <= 1'b0;
         sample_d <= 1'b0;
         byte_cnt <= '0;
      end else begin
         pins     <= '{ce_n: slot.ce_n, ck_en: slot.ck_en, dq_out: slot.dq_out,
                       dq_oe: slot.dq_oe};
         sample_q <= slot.sample;
         sample_d <= sample_q;   // Device answers one pin cycle later
         if (sample_d)
            byte_cnt <= byte_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (sample_d)
         rd_hold <= {rd_hold[HOLD_W-`PSRAM_BYTE_W-1:0], dq_in};
   end

   // Last byte goes straight from the pins into the word
   assign rd_word  = {rd_hold, dq_in};
   assign rd_valid = sample_d && (byte_cnt == BCNT_W'(NBYTES - 1));

   // Final byte lands one cycle after the last clocked pin cycle
   a_rd_in_window: assert property (@(posedge clk) disable iff (rst)
      rd_valid |-> $past(!pins.ce_n));

endmodule

`default_nettype wire

// ==== rtl/psram_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psram_ctrl_macros.svh"

module psram_ctrl_top (
   input  logic                      clk,
   input  logic                      rst,
   input  axil_pkg::axil_req_t       axil_req,
   output axil_pkg::axil_rsp_t       axil_rsp,
   output opi_pkg::opi_pins_t        pins,
   input  logic [`PSRAM_BYTE_W-1:0]  dq_in
);
   import opi_pkg::*;

   opi_cmd_t                  cmd;
   logic                      cmd_valid;
   logic                      cmd_ready;
   opi_slot_t                 slot;       // One bus cycle ahead of the pins
   logic                      wr_done;
   logic [`PSRAM_DATA_W-1:0]  rd_word;
   logic                      rd_valid;

   axil_port axil_port_inst (
      .clk       (clk),
      .rst       (rst),
      .axil_req  (axil_req),
      .axil_rsp  (axil_rsp),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .wr_done   (wr_done),
      .rd_word   (rd_word),
      .rd_valid  (rd_valid)
   );

   opi_sequencer opi_sequencer_inst (
      .clk       (clk),
      .rst       (rst),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .slot      (slot),
      .wr_done   (wr_done)
   );

   opi_io opi_io_inst (
      .clk       (clk),
      .rst       (rst),
      .slot      (slot),
      .pins      (pins),
      .dq_in     (dq_in),
      .rd_word   (rd_word),
      .rd_valid  (rd_valid)
   );

endmodule

`default_nettype wire

// ==== verification/opi_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psram_ctrl_macros.svh"

module opi_mem_model (
   input  logic                      clk,
   input  logic                      rst,
   input  opi_pkg::opi_pins_t        pins,
   output logic [`PSRAM_BYTE_W-1:0]  dq_in
);
   import opi_pkg::*;

   localparam int RD_FIRST = 5 + `PSRAM_LATENCY;   // First read data request cycle

   logic [`PSRAM_DATA_W-1:0]  mem [0:`PSRAM_MEM_WORDS-1];
   logic [`PSRAM_DATA_W-1:0]  regs [0:`PSRAM_REG_COUNT-1];
   int                        pos;       // Clocked pin cycle within the CS window
   logic [`PSRAM_BYTE_W-1:0]  cmd;
   logic [`PSRAM_ADDR_W-1:0]  addr;
   logic [`PSRAM_DATA_W-1:0]  word;      // Write data in, read data out
   logic                      is_wr;
   logic                      is_reg;

   initial begin
      for (int i = 0; i < `PSRAM_MEM_WORDS; i++)
         mem[i] = '0;
      for (int i = 0; i < `PSRAM_REG_COUNT; i++)
         regs[i] = '0;
      dq_in = '0;
   end

   assign is_wr  = (cmd == `PSRAM_CMD_MEM_WR) || (cmd == `PSRAM_CMD_REG_WR);
   assign is_reg = (cmd == `PSRAM_CMD_REG_RD) || (cmd == `PSRAM_CMD_REG_WR);

   always @(posedge clk) begin
      if (rst || pins.ce_n) begin
         pos   <= 0;
         dq_in <= '0;
      end else begin
         pos <= pos + 1;
         if (pos == 0) begin
            cmd <= pins.dq_out;
         end else if (pos <= 4) begin
            addr <= {addr[`PSRAM_ADDR_W-`PSRAM_BYTE_W-1:0], pins.dq_out};
         end else if (is_wr && pos <= 8) begin
            word = {word[`PSRAM_DATA_W-`PSRAM_BYTE_W-1:0], pins.dq_out};
            if (pos == 8) begin
               if (is_reg)
                  regs[addr] <= word;
               else
                  mem[addr] <= word;
            end
         end else if (!is_wr && pos >= RD_FIRST && pos < RD_FIRST + 4) begin
            if (pos == RD_FIRST)
               word = is_reg ? regs[addr] : mem[addr];
            // Byte goes out one pin cycle after its request
            dq_in <= word[`PSRAM_DATA_W-1 - `PSRAM_BYTE_W*(pos-RD_FIRST) -: `PSRAM_BYTE_W];
         end
      end
   end

endmodule

`default_nettype wire

// ==== verification/psram_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psram_ctrl_macros.svh"

module psram_ctrl_tb;
   import axil_pkg::*;
   import opi_pkg::*;

   localparam int MAX_DELAY = 4;   // Ready back-pressure in cycles
   localparam opi_pins_t PINS_IDLE = '{ce_n: 1'b1, ck_en: 1'b0, dq_out: '0, dq_oe: 1'b0};

   typedef struct packed {
      logic                      wr;
      logic [`PSRAM_ADDR_W-1:0]  addr;
      logic [`PSRAM_DATA_W-1:0]  data;
      logic [3:0]                strb;
      logic [3:0]                delay;
      axil_resp_e                exp_resp;
      logic [`PSRAM_DATA_W-1:0]  exp_data;
      logic                      chk_data;
   } entry_t;

   logic                      clk;
   logic                      rst;
   axil_req_t                 axil_req;
   axil_rsp_t                 axil_rsp;
   opi_pins_t                 pins;
   logic [`PSRAM_BYTE_W-1:0]  dq_in;

   entry_t                    table_q[$];
   logic [`PSRAM_DATA_W-1:0]  wd [0:7];
   integer                    seed;
   int                        cycle_cnt;
   int                        cycle_limit;
   int                        exp_windows;    // OKAY entries reach the bus
   int                        low_cnt;
   int                        high_cnt;
   int                        windows;
   logic                      seen_cs;
   logic [`PSRAM_BYTE_W-1:0]  win_cmd;

   psram_ctrl_top psram_ctrl_top_inst (
      .clk      (clk),
      .rst      (rst),
      .axil_req (axil_req),
      .axil_rsp (axil_rsp),
      .pins     (pins),
      .dq_in    (dq_in)
   );

   opi_mem_model opi_mem_model_inst (
      .clk   (clk),
      .rst   (rst),
      .pins  (pins),
      .dq_in (dq_in)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_on_error();
      $display("Checks failed");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_data(input string name, input logic [`PSRAM_DATA_W-1:0] got,
                             input logic [`PSRAM_DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_pins(input string name, input opi_pins_t got, input opi_pins_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   function automatic logic is_write_cmd(input logic [`PSRAM_BYTE_W-1:0] cmd_byte);
      return (cmd_byte == `PSRAM_CMD_MEM_WR) || (cmd_byte == `PSRAM_CMD_REG_WR);
   endfunction

   function automatic int expected_window(input logic [`PSRAM_BYTE_W-1:0] cmd_byte);
      // Command, 4 address and 4 data bytes, reads add the dummy cycles
      if (is_write_cmd(cmd_byte))
         return 9;
      return 9 + `PSRAM_LATENCY;
   endfunction

   task automatic add_write(input logic [`PSRAM_ADDR_W-1:0] addr,
                            input logic [`PSRAM_DATA_W-1:0] data,
                            input logic [3:0] strb, input axil_resp_e resp);
      entry_t e;
      e = '{wr: 1'b1, addr: addr, data: data, strb: strb, delay: '0,
            exp_resp: resp, exp_data: '0, chk_data: 1'b0};
      e.delay = 4'($unsigned($random(seed)) % (MAX_DELAY + 1));
      if (resp == AXIL_OKAY)
         exp_windows++;
      table_q.push_back(e);
   endtask

   task automatic add_read(input logic [`PSRAM_ADDR_W-1:0] addr, input axil_resp_e resp,
                           input logic [`PSRAM_DATA_W-1:0] data, input logic chk);
      entry_t e;
      e = '{wr: 1'b0, addr: addr, data: '0, strb: '0, delay: '0,
            exp_resp: resp, exp_data: data, chk_data: chk};
      e.delay = 4'($unsigned($random(seed)) % (MAX_DELAY + 1));
      if (resp == AXIL_OKAY)
         exp_windows++;
      table_q.push_back(e);
   endtask

   task automatic check_held(input entry_t e);
      if (e.wr) begin
         check_bit("bvalid", axil_rsp.bvalid, 1'b1);
         check_resp("bresp", axil_rsp.bresp, e.exp_resp);
      end else begin
         check_bit("rvalid", axil_rsp.rvalid, 1'b1);
         check_resp("rresp", axil_rsp.rresp, e.exp_resp);
         if (e.chk_data)
            check_data("rdata", axil_rsp.rdata, e.exp_data);
      end
   endtask

   task automatic apply_entry(input entry_t e);
      logic err;
      err = (e.exp_resp != AXIL_OKAY);   // No bus traffic expected
      if (e.wr) begin
         axil_req.awvalid <= 1'b1;
         axil_req.awaddr  <= e.addr;
         axil_req.wvalid  <= 1'b1;
         axil_req.wdata   <= e.data;
         axil_req.wstrb   <= e.strb;
      end else begin
         axil_req.arvalid <= 1'b1;
         axil_req.araddr  <= e.addr;
      end
      do begin
         @(posedge clk);
         if (err)
            check_pins("pins", pins, PINS_IDLE);
      end while (!(e.wr ? axil_rsp.awready : axil_rsp.arready));
      if (e.wr)
         check_bit("wready", axil_rsp.wready, 1'b1);
      axil_req.awvalid <= 1'b0;
      axil_req.wvalid  <= 1'b0;
      axil_req.arvalid <= 1'b0;
      do begin
         @(posedge clk);
         if (err)
            check_pins("pins", pins, PINS_IDLE);
      end while (!(e.wr ? axil_rsp.bvalid : axil_rsp.rvalid));
      check_held(e);
      repeat (e.delay) begin
         @(posedge clk);
         check_held(e);
      end
      if (e.wr)
         axil_req.bready <= 1'b1;
      else
         axil_req.rready <= 1'b1;
      @(posedge clk);   // Handshake edge
      check_held(e);
      axil_req.bready <= 1'b0;
      axil_req.rready <= 1'b0;
   endtask

   // Timeout
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= cycle_limit) begin
         $display("ERROR at %0t: run did not finish within %0d cycles", $time, cycle_limit);
         stop_on_error();
      end
   end

   // Chip select window and gap at the pins
   always @(posedge clk) begin
      if (rst) begin
         low_cnt  = 0;
         high_cnt = 0;
         seen_cs  = 1'b0;
      end else if (!pins.ce_n) begin
         if (low_cnt == 0) begin
            win_cmd = pins.dq_out;
            if (seen_cs && high_cnt < `PSRAM_CSHI) begin
               $display("ERROR at %0t: chip select high for only %0d cycles", $time, high_cnt);
               stop_on_error();
            end
         end
         check_bit("ck_en", pins.ck_en, 1'b1);
         // Command and address always driven, data only on writes
         check_bit("dq_oe", pins.dq_oe, (low_cnt < 5) || is_write_cmd(win_cmd));
         low_cnt++;
         high_cnt = 0;
      end else begin
         if (low_cnt != 0) begin
            check_count("ce_n low window", low_cnt, expected_window(win_cmd));
            windows++;
            seen_cs = 1'b1;
         end
         low_cnt = 0;
         high_cnt++;
      end
   end

   initial begin
      rst         = 1'b1;
      axil_req    = '0;
      cycle_cnt   = 0;
      windows     = 0;
      exp_windows = 0;
      seed        = 32'hd7646a66;
      for (int i = 0; i < 8; i++)
         wd[i] = $random(seed);

      add_write(32'h0000_0000, wd[0], 4'hf, AXIL_OKAY);
      add_write(32'h0000_0ffc, wd[1], 4'hf, AXIL_OKAY);   // Highest word
      add_write(32'h0000_0010, wd[2], 4'hf, AXIL_OKAY);
      add_read(32'h0000_0000, AXIL_OKAY, wd[0], 1'b1);
      add_read(32'h0000_0ffc, AXIL_OKAY, wd[1], 1'b1);
      add_read(32'h0000_0010, AXIL_OKAY, wd[2], 1'b1);
      // Register 2 and memory word 2 are separate
      add_write(32'h0000_0008, wd[3], 4'hf, AXIL_OKAY);
      add_write(32'h8000_0002, wd[4], 4'hf, AXIL_OKAY);
      add_read(32'h0000_0008, AXIL_OKAY, wd[3], 1'b1);
      add_read(32'h8000_0002, AXIL_OKAY, wd[4], 1'b1);
      add_write(32'h8000_0000, wd[5], 4'hf, AXIL_OKAY);
      add_read(32'h8000_0000, AXIL_OKAY, wd[5], 1'b1);
      add_read(32'h8000_0003, AXIL_OKAY, '0, 1'b1);
      add_read(32'h0000_0006, AXIL_SLVERR, '0, 1'b0);
      add_write(32'h0000_0012, wd[6], 4'hf, AXIL_SLVERR);
      add_write(32'h0000_0000, wd[6], 4'h7, AXIL_SLVERR);
      add_read(32'h0000_0000, AXIL_OKAY, wd[0], 1'b1);
      add_write(32'h0000_1000, wd[6], 4'hf, AXIL_DECERR);
      add_read(32'h0000_1000, AXIL_DECERR, '0, 1'b0);
      add_write(32'h8000_0004, wd[6], 4'hf, AXIL_DECERR);
      add_read(32'h8000_0004, AXIL_DECERR, '0, 1'b0);
      add_write(32'h0000_0020, wd[6], 4'hf, AXIL_OKAY);
      add_write(32'h0000_0800, wd[7], 4'hf, AXIL_OKAY);
      add_read(32'h0000_0020, AXIL_OKAY, wd[6], 1'b1);
      add_read(32'h0000_0800, AXIL_OKAY, wd[7], 1'b1);
      add_read(32'h0000_0010, AXIL_OKAY, wd[2], 1'b1);   // Untouched by misaligned write
      cycle_limit = table_q.size() * (20 + `PSRAM_LATENCY + MAX_DELAY) + 50;

      repeat (5) @(posedge clk);
      rst <= 1'b0;
      check_pins("pins", pins, PINS_IDLE);
      check_bit("bvalid", axil_rsp.bvalid, 1'b0);
      check_bit("rvalid", axil_rsp.rvalid, 1'b0);
      check_bit("awready", axil_rsp.awready, 1'b0);
      check_bit("arready", axil_rsp.arready, 1'b0);

      foreach (table_q[i])
         apply_entry(table_q[i]);

      repeat (`PSRAM_CSHI + 2) @(posedge clk);
      check_count("bus transactions", windows, exp_windows);
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
rtl/axil_pkg.sv
rtl/opi_pkg.sv
rtl/axil_port.sv
rtl/opi_sequencer.sv
rtl/opi_io.sv
rtl/psram_ctrl_top.sv
verification/opi_mem_model.sv
verification/psram_ctrl_tb.sv
